/* list.f */
+incdir+design
+incdir+tb
design/cart_profile_pkg.sv
design/region_scanner.sv
design/cart_id_matcher.sv
design/profile_resolver.sv
design/cart_profile_top.sv
tb/tb_cart_profile.sv

/* Makefile */
# Verilator build and run of the cartridge profile testbench

BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f list.f \
		--top-module tb_cart_profile -Mdir $(BUILD) -o sim_cart_profile
	./$(BUILD)/sim_cart_profile

clean:
	rm -rf $(BUILD)

/* tb/cart_profile_cases.svh */
//////////////////////////////////////////////////////////////////////
// cartridge profile test cases
// product id and region words as written to the header, then the
// region, quirk class and light-gun setting each one should give
//////////////////////////////////////////////////////////////////////

`ifndef CART_PROFILE_CASES_SVH
`define CART_PROFILE_CASES_SVH

localparam int num_cases = 16;

// low byte of a region word holds the code and the high byte may add a letter
localparam case_t case_table [num_cases] = '{
	// id          rgn_a  rgn_b  region     quirk          gun            delay
	'{"T-081276", "JU", "  ", REGION_US, QUIRK_SRAM,   GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"MK-1215 ", "  ", " E", REGION_EU, QUIRK_EEPROM, GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"T-113016", " J", "  ", REGION_JP, QUIRK_NORAM,  GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"T-89016 ", "EJ", "  ", REGION_EU, QUIRK_FIFO,   GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"T-574023", " 1", "  ", REGION_JP, QUIRK_PIER,   GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"MK-1229 ", " 4", "  ", REGION_US, QUIRK_SVP,    GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"T-35036 ", " 8", "  ", REGION_EU, QUIRK_FMBUSY, GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"T-68???-", " A", "  ", REGION_EU, QUIRK_SCHAN,  GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{" GM 0000", " F", "  ", REGION_US, QUIRK_SRAM00, GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"GM 00000", " J", " U", REGION_US, QUIRK_NONE,   GUN_MENACER,   `GUN_DELAY_DEFAULT},
	'{"MK-1533 ", " C", "  ", REGION_US, QUIRK_NONE,   GUN_MENACER,   8'd100},
	'{"T-95096-", "  ", "  ", REGION_US, QUIRK_NONE,   GUN_JUSTIFIER, 8'd52},
	'{"T-95136-", " 9", "  ", REGION_EU, QUIRK_NONE,   GUN_JUSTIFIER, 8'd30},
	'{"MK-1658 ", " B", "  ", REGION_EU, QUIRK_NONE,   GUN_MENACER,   8'd120},
	'{"T-081156", " 2", "  ", REGION_US, QUIRK_NONE,   GUN_MENACER,   8'd126},
	'{"G-4060  ", "J8", "  ", REGION_EU, QUIRK_EEPROM, GUN_MENACER,   `GUN_DELAY_DEFAULT}
};

`endif

/* tb/tb_cart_profile.sv */
//////////////////////////////////////////////////////////////////////
// cartridge profile testbench
// streams one cart header per table row into the DUT and checks
// region, hold, quirk flags and light-gun outputs
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cart_profile_settings.svh"

module tb_cart_profile import cart_profile_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [63:0] id;
		logic [15:0] rgn_a;
		logic [15:0] rgn_b;
		region_e     region;
		cart_quirk_e quirk;
		gun_type_e   gun;
		logic [7:0]  delay;
	} case_t;

	`include "cart_profile_cases.svh"

	logic                    clk_sys;
	logic                    pll_core_locked;
	logic                    rom_loading;
	logic                    rom_wr;
	logic [`ROM_ADDR_W-1:0]  rom_addr;
	logic [`ROM_DATA_W-1:0]  rom_data;
	region_e                 region_req;
	logic                    region_export;
	logic                    core_hold;
	logic                    sram_quirk;
	logic                    sram00_quirk;
	logic                    eeprom_quirk;
	logic                    noram_quirk;
	logic                    fifo_quirk;
	logic                    pier_quirk;
	logic                    svp_quirk;
	logic                    fmbusy_quirk;
	logic                    schan_quirk;
	gun_type_e               gun_type;
	logic [`GUN_DELAY_W-1:0] gun_sensor_delay;
	logic [8:0]              quirk_flags;

	assign quirk_flags = {sram_quirk, sram00_quirk, eeprom_quirk, noram_quirk, fifo_quirk,
		pier_quirk, svp_quirk, fmbusy_quirk, schan_quirk};

	cart_profile_top i_cart_profile_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;    // 25 MHz
	end

	// about 18 cycles per row plus margin
	initial begin
		#(num_cases * 60 * 40 + 2000);
		$display("watchdog expired before all cases finished");
		$display("Simulation failed");
		$fatal(1, "run did not complete in time");
	end

	//////////////////////////////////////////////////////////////////////
	// checks and helpers
	task automatic expect_val(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("[ERROR] t=%0t %s: got 'h%0h, expected 'h%0h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// flag order sram, sram00, eeprom, noram, fifo, pier, svp, fmbusy, schan
	function automatic logic [8:0] expected_flags(input cart_quirk_e q);
		case (q)
			QUIRK_SRAM:   return 9'b100000000;
			QUIRK_SRAM00: return 9'b010000000;
			QUIRK_EEPROM: return 9'b001000000;
			QUIRK_NORAM:  return 9'b000100000;
			QUIRK_FIFO:   return 9'b000010000;
			QUIRK_PIER:   return 9'b000001000;
			QUIRK_SVP:    return 9'b000000100;
			QUIRK_FMBUSY: return 9'b000000010;
			QUIRK_SCHAN:  return 9'b000000001;
			default:      return 9'b000000000;
		endcase
	endfunction

	task automatic check_reset_values();
		expect_val("core_hold after reset", int'(core_hold), 0);
		expect_val("quirk flags after reset", int'(quirk_flags), 0);
		expect_val("region_req after reset", int'(region_req), int'(REGION_JP));
		expect_val("region_export after reset", int'(region_export), 0);
		expect_val("gun_type after reset", int'(gun_type), int'(GUN_MENACER));
		expect_val("gun delay after reset", int'(gun_sensor_delay), int'(`GUN_DELAY_DEFAULT));
	endtask

	// starts and ends on a falling edge
	task automatic write_word(input logic [`ROM_ADDR_W-1:0] addr, input logic [15:0] data);
		rom_wr   = 1'b1;
		rom_addr = addr;
		rom_data = data;
		@(negedge clk_sys);
		rom_wr = 1'b0;
	endtask

	task automatic write_filler(input int count);
		logic [31:0] r;
		repeat (count) begin
			r = $urandom;
			write_word((r[`ROM_ADDR_W-1:0] | 25'h1000) & ~25'h1, 16'($urandom));    // past header
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one cart download per row
	task automatic run_case(input case_t c, input int row);
		logic [7:0] fill;
		fill = 8'($urandom);
		rom_loading = 1'b1;
		@(negedge clk_sys);
		expect_val($sformatf("row %0d flags at load start", row), int'(quirk_flags), 0);
		expect_val($sformatf("row %0d core_hold idle", row), int'(core_hold), 0);

		write_word(`HDR_ID_0, {c.id[63:56], fill});
		write_word(`HDR_ID_1, {c.id[47:40], c.id[55:48]});    // stored byte swapped
		write_word(`HDR_ID_2, {c.id[31:24], c.id[39:32]});
		write_word(`HDR_ID_3, {c.id[15:8], c.id[23:16]});
		write_word(`HDR_ID_4, {fill, c.id[7:0]});
		write_word(`HDR_ID_MATCH, 16'($urandom));
		expect_val($sformatf("row %0d quirk flags", row), int'(quirk_flags),
			int'(expected_flags(c.quirk)));
		expect_val($sformatf("row %0d gun_type", row), int'(gun_type), int'(c.gun));
		expect_val($sformatf("row %0d gun delay", row), int'(gun_sensor_delay), int'(c.delay));

		write_word(`HDR_REGION_A, c.rgn_a);
		write_word(`HDR_REGION_B, c.rgn_b);
		write_filler(3);
		write_word(`HDR_END, 16'($urandom));
		expect_val($sformatf("row %0d core_hold early", row), int'(core_hold), 0);
		@(negedge clk_sys);
		expect_val($sformatf("row %0d core_hold raised", row), int'(core_hold), 1);
		expect_val($sformatf("row %0d region_req", row), int'(region_req), int'(c.region));
		expect_val($sformatf("row %0d region_export", row), int'(region_export),
			int'(c.region != REGION_JP));

		write_filler(2);
		rom_loading = 1'b0;
		@(negedge clk_sys);
		expect_val($sformatf("row %0d core_hold after load end", row), int'(core_hold), 1);
		@(negedge clk_sys);
		expect_val($sformatf("row %0d core_hold released", row), int'(core_hold), 0);
		expect_val($sformatf("row %0d region held", row), int'(region_req), int'(c.region));
	endtask

	initial begin
		void'($urandom(32'h0175_ca47));
		pll_core_locked = 1'b0;
		rom_loading     = 1'b0;
		rom_wr          = 1'b0;
		rom_addr        = '0;
		rom_data        = '0;
		repeat (2) @(negedge clk_sys);
		pll_core_locked = 1'b1;
		@(negedge clk_sys);
		check_reset_values();

		for (int i = 0; i < num_cases; i++) begin
			run_case(case_table[i], i);
		end

		// async reset in the middle of a load while the hold is up
		rom_loading = 1'b1;
		@(negedge clk_sys);
		write_word(`HDR_ID_MATCH, 16'($urandom));    // id of the last row is still held
		write_word(`HDR_END, 16'($urandom));
		@(negedge clk_sys);
		expect_val("core_hold before reset", int'(core_hold), 1);
		expect_val("quirk flags before reset", int'(quirk_flags),
			int'(expected_flags(case_table[num_cases-1].quirk)));
		pll_core_locked = 1'b0;
		#1;
		check_reset_values();
		@(negedge clk_sys);
		rom_loading     = 1'b0;
		pll_core_locked = 1'b1;

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/cart_profile_top.sv */
//////////////////////////////////////////////////////////////////////
// cartridge profile top level
// scanner and id matcher watch the rom stream, resolver merges them
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cart_profile_settings.svh"

module cart_profile_top import cart_profile_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      pll_core_locked,
	input  wire                      rom_loading,
	input  wire                      rom_wr,
	input  wire [`ROM_ADDR_W-1:0]    rom_addr,
	input  wire [`ROM_DATA_W-1:0]    rom_data,
	output wire region_e             region_req,
	output wire                      region_export,
	output wire                      core_hold,
	output wire                      sram_quirk,
	output wire                      sram00_quirk,
	output wire                      eeprom_quirk,
	output wire                      noram_quirk,
	output wire                      fifo_quirk,
	output wire                      pier_quirk,
	output wire                      svp_quirk,
	output wire                      fmbusy_quirk,
	output wire                      schan_quirk,
	output wire gun_type_e           gun_type,
	output wire [`GUN_DELAY_W-1:0]   gun_sensor_delay
);

	wire                    hdr_j;
	wire                    hdr_u;
	wire                    hdr_e;
	wire                    hdr_ready;
	cart_quirk_e            quirk_class;
	gun_type_e              id_gun_type;
	logic [`GUN_DELAY_W-1:0] id_gun_delay;

	region_scanner i_region_scanner (
		.clk_sys         (clk_sys),
		.pll_core_locked (pll_core_locked),
		.rom_loading     (rom_loading),
		.rom_wr          (rom_wr),
		.rom_addr        (rom_addr),
		.rom_data        (rom_data),
		.hdr_j           (hdr_j),
		.hdr_u           (hdr_u),
		.hdr_e           (hdr_e),
		.hdr_ready       (hdr_ready)
	);

	cart_id_matcher i_cart_id_matcher (
		.clk_sys          (clk_sys),
		.pll_core_locked  (pll_core_locked),
		.rom_loading      (rom_loading),
		.rom_wr           (rom_wr),
		.rom_addr         (rom_addr),
		.rom_data         (rom_data),
		.quirk_class      (quirk_class),
		.gun_type         (id_gun_type),
		.gun_sensor_delay (id_gun_delay)
	);

	profile_resolver i_profile_resolver (
		.clk_sys             (clk_sys),
		.pll_core_locked     (pll_core_locked),
		.hdr_j               (hdr_j),
		.hdr_u               (hdr_u),
		.hdr_e               (hdr_e),
		.hdr_ready           (hdr_ready),
		.quirk_class         (quirk_class),
		.gun_type_in         (id_gun_type),
		.gun_sensor_delay_in (id_gun_delay),
		.region_req          (region_req),
		.region_export       (region_export),
		.core_hold           (core_hold),
		.sram_quirk          (sram_quirk),
		.sram00_quirk        (sram00_quirk),
		.eeprom_quirk        (eeprom_quirk),
		.noram_quirk         (noram_quirk),
		.fifo_quirk          (fifo_quirk),
		.pier_quirk          (pier_quirk),
		.svp_quirk           (svp_quirk),
		.fmbusy_quirk        (fmbusy_quirk),
		.schan_quirk         (schan_quirk),
		.gun_type            (gun_type),
		.gun_sensor_delay    (gun_sensor_delay)
	);

endmodule

`default_nettype wire

/* design/profile_resolver.sv */
//////////////////////////////////////////////////////////////////////
// profile resolver
// picks the console region once the header is in, holds the console
// while it changes, and fans the quirk class out to flags
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cart_profile_settings.svh"

module profile_resolver import cart_profile_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      pll_core_locked,
	input  wire                      hdr_j,
	input  wire                      hdr_u,
	input  wire                      hdr_e,
	input  wire                      hdr_ready,
	input  wire cart_quirk_e         quirk_class,
	input  wire gun_type_e           gun_type_in,
	input  wire [`GUN_DELAY_W-1:0]   gun_sensor_delay_in,
	output region_e                  region_req,
	output logic                     region_export,
	output logic                     core_hold,
	output logic                     sram_quirk,
	output logic                     sram00_quirk,
	output logic                     eeprom_quirk,
	output logic                     noram_quirk,
	output logic                     fifo_quirk,
	output logic                     pier_quirk,
	output logic                     svp_quirk,
	output logic                     fmbusy_quirk,
	output logic                     schan_quirk,
	output gun_type_e                gun_type,
	output logic [`GUN_DELAY_W-1:0]  gun_sensor_delay
);

	logic ready_q;

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			ready_q    <= 1'b0;
			region_req <= REGION_JP;
			core_hold  <= 1'b0;
		end else begin
			ready_q <= hdr_ready;

			// header just landed, latch region and hold the console
			if (hdr_ready && !ready_q) begin
				core_hold <= 1'b1;
				if (hdr_u) region_req <= REGION_US;
				else if (hdr_e) region_req <= REGION_EU;
				else if (hdr_j) region_req <= REGION_JP;
				else region_req <= REGION_US;    // no region at all, assume us
			end

			if (!hdr_ready && ready_q) core_hold <= 1'b0;    // load finished
		end
	end

	assign region_export = (region_req != REGION_JP);

	//////////////////////////////////////////////////////////////////////
	// one-hot quirk flags
	assign sram_quirk   = (quirk_class == QUIRK_SRAM);
	assign sram00_quirk = (quirk_class == QUIRK_SRAM00);
	assign eeprom_quirk = (quirk_class == QUIRK_EEPROM);
	assign noram_quirk  = (quirk_class == QUIRK_NORAM);
	assign fifo_quirk   = (quirk_class == QUIRK_FIFO);
	assign pier_quirk   = (quirk_class == QUIRK_PIER);
	assign svp_quirk    = (quirk_class == QUIRK_SVP);
	assign fmbusy_quirk = (quirk_class == QUIRK_FMBUSY);
	assign schan_quirk  = (quirk_class == QUIRK_SCHAN);

	assign gun_type         = gun_type_in;           // already registered upstream
	assign gun_sensor_delay = gun_sensor_delay_in;

endmodule

`default_nettype wire

/* design/cart_id_matcher.sv */
//////////////////////////////////////////////////////////////////////
// cart id matcher
// builds the 8 char product id from the header and looks it up in
// the compatibility quirk and light-gun tables
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cart_profile_settings.svh"

module cart_id_matcher import cart_profile_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     pll_core_locked,
	input  wire                     rom_loading,
	input  wire                     rom_wr,
	input  wire [`ROM_ADDR_W-1:0]   rom_addr,
	input  wire [`ROM_DATA_W-1:0]   rom_data,
	output cart_quirk_e             quirk_class,
	output gun_type_e               gun_type,
	output logic [`GUN_DELAY_W-1:0] gun_sensor_delay
);

	logic [`CART_ID_W-1:0]   cart_id;
	logic                    loading_q;
	logic                    hdr_wr;
	cart_quirk_e             quirk_lookup;
	gun_type_e               gun_type_lookup;
	logic [`GUN_DELAY_W-1:0] gun_delay_lookup;

	assign hdr_wr = rom_wr & rom_loading;

	// id payload, bytes arrive big-endian
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (rom_addr == `HDR_ID_0) cart_id[63:56] <= rom_data[15:8];
			if (rom_addr == `HDR_ID_1) cart_id[55:40] <= {rom_data[7:0], rom_data[15:8]};
			if (rom_addr == `HDR_ID_2) cart_id[39:24] <= {rom_data[7:0], rom_data[15:8]};
			if (rom_addr == `HDR_ID_3) cart_id[23:8]  <= {rom_data[7:0], rom_data[15:8]};
			if (rom_addr == `HDR_ID_4) cart_id[7:0]   <= rom_data[7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// quirk table
	always_comb begin
		case (cart_id)
			"T-081276",                       // nfl quarterback club
			"T-81406 ",
			"T-081586",
			"T-81576 ",
			"T-81476 ": quirk_lookup = QUIRK_SRAM;
			"MK-1215 ",                       // boxing titles with serial eeprom
			"G-4060  ",
			"00001211",
			"MK-1228 ",
			"G-5538  ",
			"00004076",
			"T-12046 ",                       // wily wars
			"T-12053 ",
			"G-4524  ": quirk_lookup = QUIRK_EEPROM;
			"T-113016": quirk_lookup = QUIRK_NORAM;   // fake ram check
			"T-89016 ": quirk_lookup = QUIRK_FIFO;
			"T-574023",
			"T-574013": quirk_lookup = QUIRK_PIER;
			"MK-1229 ",                       // virtua racing
			"G-7001  ": quirk_lookup = QUIRK_SVP;
			"T-35036 ",
			"T-25073 ",
			"MK-1137-": quirk_lookup = QUIRK_FMBUSY;
			"T-68???-": quirk_lookup = QUIRK_SCHAN;
			" GM 0000": quirk_lookup = QUIRK_SRAM00;
			default:    quirk_lookup = QUIRK_NONE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// light gun type and sensor timing
	always_comb begin
		gun_type_lookup  = GUN_MENACER;
		gun_delay_lookup = `GUN_DELAY_DEFAULT;
		case (cart_id)
			"MK-1533 ": gun_delay_lookup = 8'd100;    // body count
			"T-95096-": begin
				gun_type_lookup  = GUN_JUSTIFIER;
				gun_delay_lookup = 8'd52;
			end
			"T-95136-": begin
				gun_type_lookup  = GUN_JUSTIFIER;
				gun_delay_lookup = 8'd30;
			end
			"MK-1658 ": gun_delay_lookup = 8'd120;    // menacer 6-in-1
			"T-081156": gun_delay_lookup = 8'd126;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			loading_q        <= 1'b0;
			quirk_class      <= QUIRK_NONE;
			gun_type         <= GUN_MENACER;
			gun_sensor_delay <= `GUN_DELAY_DEFAULT;
		end else begin
			loading_q <= rom_loading;
			if (rom_loading && !loading_q) quirk_class <= QUIRK_NONE;

			// id is complete by the time this word goes by
			if (hdr_wr && rom_addr == `HDR_ID_MATCH) begin
				quirk_class      <= quirk_lookup;
				gun_type         <= gun_type_lookup;
				gun_sensor_delay <= gun_delay_lookup;
			end
		end
	end

endmodule

`default_nettype wire

/* design/region_scanner.sv */
//////////////////////////////////////////////////////////////////////
// region scanner
// snoops the rom write stream for the header region bytes and
// flags japan / usa / europe, then signals when the header is in
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cart_profile_settings.svh"

module region_scanner (
	input  wire                     clk_sys,
	input  wire                     pll_core_locked,
	input  wire                     rom_loading,
	input  wire                     rom_wr,
	input  wire [`ROM_ADDR_W-1:0]   rom_addr,
	input  wire [`ROM_DATA_W-1:0]   rom_data,
	output logic                    hdr_j,
	output logic                    hdr_u,
	output logic                    hdr_e,
	output logic                    hdr_ready
);

	logic       loading_q;
	logic       load_rise;
	logic       load_fall;
	logic       hdr_wr;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hrgn;

	assign load_rise = rom_loading & ~loading_q;
	assign load_fall = ~rom_loading & loading_q;
	assign hdr_wr    = rom_wr & rom_loading;

	assign lo_byte = rom_data[7:0];
	assign hi_byte = rom_data[15:8];
	assign hrgn    = rom_data[3:0] - 4'd7;    // 'A'..'F' -> 0xA..0xF

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			loading_q <= 1'b0;
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
			hdr_e     <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			loading_q <= rom_loading;

			if (load_rise) begin
				{hdr_j, hdr_u, hdr_e} <= 3'b000;    // new cart, forget old region
			end
			if (load_fall) hdr_ready <= 1'b0;

			if (hdr_wr) begin
				//////////////////////////////////////////////////////////////////////
				// first region word, low byte may be a letter or a bit code
				if (rom_addr == `HDR_REGION_A) begin
					if (lo_byte == "J") hdr_j <= 1'b1;
					else if (lo_byte == "U") hdr_u <= 1'b1;
					else if (lo_byte == "E") hdr_e <= 1'b1;
					else if (lo_byte >= "0" && lo_byte <= "9") begin
						{hdr_e, hdr_u, hdr_j} <= {lo_byte[3], lo_byte[2], lo_byte[0]};
					end else if (lo_byte >= "A" && lo_byte <= "F") begin
						{hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};
					end

					// high byte letter wins over the low byte code
					if (hi_byte == "J") hdr_j <= 1'b1;
					else if (hi_byte == "U") hdr_u <= 1'b1;
					else if (hi_byte == "E") hdr_e <= 1'b1;
				end

				// second word only ever carries a letter
				if (rom_addr == `HDR_REGION_B) begin
					if (lo_byte == "J") hdr_j <= 1'b1;
					else if (lo_byte == "U") hdr_u <= 1'b1;
					else if (lo_byte == "E") hdr_e <= 1'b1;
				end

				if (rom_addr == `HDR_END) hdr_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/cart_profile_pkg.sv */
//////////////////////////////////////////////////////////////////////
// cartridge profiling types
// region request, quirk class and light-gun type
//////////////////////////////////////////////////////////////////////

`default_nettype none

package cart_profile_pkg;

	// console region request, export is anything but japan
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// one class per cart, the classes never overlap
	typedef enum logic [3:0] {
		QUIRK_NONE   = 4'd0,
		QUIRK_SRAM   = 4'd1,
		QUIRK_SRAM00 = 4'd2,
		QUIRK_EEPROM = 4'd3,
		QUIRK_NORAM  = 4'd4,
		QUIRK_FIFO   = 4'd5,
		QUIRK_PIER   = 4'd6,
		QUIRK_SVP    = 4'd7,
		QUIRK_FMBUSY = 4'd8,
		QUIRK_SCHAN  = 4'd9
	} cart_quirk_e;

	typedef enum logic {
		GUN_MENACER   = 1'b0,
		GUN_JUSTIFIER = 1'b1
	} gun_type_e;

endpackage

`default_nettype wire

/* design/cart_profile_settings.svh */
//////////////////////////////////////////////////////////////////////
// cartridge profiling settings
// header offsets, stream widths and light-gun defaults shared by
// the scanner, the id matcher and the resolver
//////////////////////////////////////////////////////////////////////

`ifndef CART_PROFILE_SETTINGS_SVH
`define CART_PROFILE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// rom write stream
`define ROM_ADDR_W          25      // byte address
`define ROM_DATA_W          16      // one word per strobe, big-endian
`define CART_ID_W           64      // 8 ascii characters

//////////////////////////////////////////////////////////////////////
// header byte offsets, sized to ROM_ADDR_W
`define HDR_ID_0            25'h182 // high byte is id char 0
`define HDR_ID_1            25'h184
`define HDR_ID_2            25'h186
`define HDR_ID_3            25'h188
`define HDR_ID_4            25'h18A // low byte is the last char
`define HDR_ID_MATCH        25'h18C // id complete, run the lookup
`define HDR_REGION_A        25'h1F0
`define HDR_REGION_B        25'h1F2
`define HDR_END             25'h200 // header fully written

//////////////////////////////////////////////////////////////////////
// light gun
`define GUN_DELAY_W         8
`define GUN_DELAY_DEFAULT   8'd44   // sized to GUN_DELAY_W

`endif
